// File: bench/fetch_patterns.hex
// 0..5: per test control, [31:24] min delay, [23:16] max delay, [15:12] out of order,
// [11:8] commit policy (0 immediate, 1 none), [7:0] stall percent; 16..31: instruction words
01010000
01081000
01030019
01040100
0206101E
01051014
@10
00000013
00a00093
00108113
002081b3
40310233
0041f2b3
0052e333
006343b3
00339413
0063d493
40845513
00a525b3
00b53633
0000006f
fe0686e3
00c12023

// File: bench/fetch_unit_assert.sv
/*
 * Bound checks on request hold, decode hold under
 * back-pressure and idle outputs after reset
 */
`timescale 1ns/100ps

module fetch_unit_assert #(
  parameter int seq_num_bits = 3
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    mem_req_val,
  input logic                    mem_req_rdy,
  input logic [31:0]             mem_req_addr,
  input logic [3:0]              mem_req_opaq,
  input logic                    d_val,
  input logic                    d_rdy,
  input logic [31:0]             d_inst,
  input logic [31:0]             d_pc,
  input logic [seq_num_bits-1:0] d_seq_num
);

  // Failed assertion attempts, read by the testbench
  int fail_count = 0;

  // Request held until accepted
  req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_val && !mem_req_rdy |=>
      mem_req_val && $stable(mem_req_addr) && $stable(mem_req_opaq))
    else begin
      $error("memory request changed before it was accepted");
      fail_count++;
    end

  // Decode message frozen while stalled
  dec_hold: assert property (@(posedge clk) disable iff (rst)
    d_val && !d_rdy |=>
      d_val && $stable(d_inst) && $stable(d_pc) && $stable(d_seq_num))
    else begin
      $error("decode message changed under back-pressure");
      fail_count++;
    end

  // Nothing valid right after a reset cycle
  rst_idle: assert property (@(posedge clk) rst |=> !d_val && !mem_req_val)
    else begin
      $error("valid output in the cycle after reset");
      fail_count++;
    end

endmodule

bind fetch_unit fetch_unit_assert #(.seq_num_bits(seq_num_bits)) fetch_unit_assert_inst (
  .clk          (clk),
  .rst          (rst),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_req_addr (mem_req_addr),
  .mem_req_opaq (mem_req_opaq),
  .d_val        (d_val),
  .d_rdy        (d_rdy),
  .d_inst       (d_inst),
  .d_pc         (d_pc),
  .d_seq_num    (d_seq_num)
);

// File: bench/fetch_unit_tb.sv
/*
 * Fetch unit testbench with clock, reset, out-of-order memory
 * model, decode sink, committer and stream checks
 */
`timescale 1ns/100ps

module fetch_unit_tb;

  localparam int          num_slots    = 4;
  localparam int          seq_num_bits = 3;
  localparam logic [31:0] reset_pc     = 32'h0000_0100;

  logic                    clk;
  logic                    rst;
  logic                    mem_req_val;
  logic                    mem_req_rdy;
  logic [31:0]             mem_req_addr;
  logic [3:0]              mem_req_opaq;
  logic                    mem_resp_val;
  logic [3:0]              mem_resp_opaq;
  logic [31:0]             mem_resp_data;
  logic                    d_val;
  logic                    d_rdy;
  logic [31:0]             d_inst;
  logic [31:0]             d_pc;
  logic [seq_num_bits-1:0] d_seq_num;
  logic                    commit_val;
  logic [seq_num_bits-1:0] commit_seq_num;

  // Controls at 0..5 and instruction words at 16..31
  logic [31:0] pat [0:31];
  int          min_dly;
  int          max_dly;
  int          stall_pct;
  int          commit_budget;
  bit          ooo;
  bit          agent_on;
  int          cyc;
  int          rx_count;
  int          tx_count;
  int          errors;
  int          tests_failed;
  // Outstanding memory reads
  logic [31:0]             q_addr [$];
  int                      q_tag [$];
  int                      q_due [$];
  logic [seq_num_bits-1:0] commit_q [$];

  fetch_unit #(
    .num_slots    (num_slots),
    .seq_num_bits (seq_num_bits),
    .reset_pc     (reset_pc)
  ) fetch_unit_inst (.*);

  always #20 clk = ~clk;

  // Memory contents mixed with the full address
  function automatic logic [31:0] mem_word(logic [31:0] addr);
    return pat[16 + int'(addr[5:2])] ^ addr;
  endfunction

  // --------------------
  // Request check, sequential pc and round-robin tag
  task automatic check_req();
    logic [31:0] exp_addr;
    logic [3:0]  exp_opaq;
    exp_addr = reset_pc + 32'(4 * tx_count);
    exp_opaq = 4'(tx_count % num_slots);
    assert (mem_req_addr == exp_addr)
      else begin
        $display("Fail mem_req_addr got %h exp %h", mem_req_addr, exp_addr);
        errors++;
      end
    assert (mem_req_opaq == exp_opaq)
      else begin
        $display("Fail mem_req_opaq got %h exp %h", mem_req_opaq, exp_opaq);
        errors++;
      end
    tx_count++;
  endtask

  // Decode check against the sequential rule
  task automatic check_msg();
    logic [31:0]             exp_pc;
    logic [seq_num_bits-1:0] exp_seq;
    exp_pc  = reset_pc + 32'(4 * rx_count);
    exp_seq = seq_num_bits'(rx_count % 8);
    assert (d_pc == exp_pc)
      else begin
        $display("Fail d_pc got %h exp %h", d_pc, exp_pc);
        errors++;
      end
    assert (d_inst == mem_word(exp_pc))
      else begin
        $display("Fail d_inst got %h exp %h", d_inst, mem_word(exp_pc));
        errors++;
      end
    assert (d_seq_num == exp_seq)
      else begin
        $display("Fail d_seq_num got %h exp %h", d_seq_num, exp_seq);
        errors++;
      end
    rx_count++;
    commit_q.push_back(exp_seq);
  endtask

  // --------------------
  // Memory model, decode sink and committer
  initial begin : agent
    int pick;
    void'($urandom(60));
    forever begin
      @(negedge clk);
      cyc++;
      mem_resp_val = 1'b0;
      commit_val   = 1'b0;
      if (agent_on) begin
        // Commit strictly after the decode transfer
        if (commit_budget > 0 && commit_q.size() > 0) begin
          commit_val     = 1'b1;
          commit_seq_num = commit_q.pop_front();
          commit_budget--;
        end
        // Accept a request at the coming edge
        mem_req_rdy = ($urandom % 100) >= stall_pct;
        if (mem_req_val && mem_req_rdy) begin
          check_req();
          q_addr.push_back(mem_req_addr);
          q_tag.push_back(int'(mem_req_opaq));
          q_due.push_back(cyc + min_dly + int'($urandom % (max_dly - min_dly + 1)));
        end
        // One response per cycle from the oldest or any ready entry
        pick = -1;
        if (!ooo) begin
          if (q_due.size() > 0 && q_due[0] <= cyc) pick = 0;
        end else begin
          for (int i = 0; i < q_due.size(); i++)
            if (q_due[i] <= cyc && (pick < 0 || $urandom % 2 == 0)) pick = i;
        end
        if (pick >= 0) begin
          mem_resp_val  = 1'b1;
          mem_resp_opaq = 4'(q_tag[pick]);
          mem_resp_data = mem_word(q_addr[pick]);
          q_addr.delete(pick);
          q_tag.delete(pick);
          q_due.delete(pick);
        end
        // Decode sink with random stalls
        d_rdy = ($urandom % 100) >= stall_pct;
        if (d_val && d_rdy) check_msg();
      end else begin
        mem_req_rdy = 1'b0;
        d_rdy       = 1'b0;
      end
    end
  end

  // --------------------
  // Control word holds delay range, ooo flag, commit policy and stall percent
  task automatic configure(int t);
    logic [31:0] c;
    c             = pat[t];
    min_dly       = int'(c[31:24]);
    max_dly       = int'(c[23:16]);
    ooo           = (c[15:12] != 0);
    commit_budget = (c[11:8] == 0) ? 1000000 : 0;
    stall_pct     = int'(c[7:0]);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    agent_on = 1'b0;
    @(negedge clk);
    rst = 1'b1;
    q_addr.delete();
    q_tag.delete();
    q_due.delete();
    commit_q.delete();
    rx_count = 0;
    tx_count = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    agent_on = 1'b1;
  endtask

  task automatic wait_rx(int target, int limit);
    int n;
    n = 0;
    while (rx_count < target && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rx_count < target) begin
      $display("Timeout: only %0d of %0d decode messages arrived", rx_count, target);
      errors++;
    end
  endtask

  // No decode traffic allowed for a while
  task automatic quiet_check(int cycles, int expect_n);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (!d_val)
        else begin
          $display("Fail d_val got %h exp %h", d_val, 1'b0);
          errors++;
        end
    end
    assert (rx_count == expect_n)
      else begin
        $display("Fail rx_count got %h exp %h", rx_count, expect_n);
        errors++;
      end
  endtask

  task automatic report(int t, string name, int err_before);
    if (errors == err_before) begin
      $display("Test %0d %s: ok", t, name);
    end else begin
      $display("Test %0d %s: %0d errors", t, name, errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic stream_test(int t, string name, int count);
    int e0;
    e0 = errors;
    configure(t - 1);
    reset_dut();
    wait_rx(count, 2000);
    report(t, name, e0);
  endtask

  initial begin : main
    int e0;
    int assert_fails;
    clk            = 0;
    rst            = 1;
    agent_on       = 0;
    mem_req_rdy    = 0;
    mem_resp_val   = 0;
    mem_resp_opaq  = 0;
    mem_resp_data  = 0;
    d_rdy          = 0;
    commit_val     = 0;
    commit_seq_num = 0;
    cyc            = 0;
    rx_count       = 0;
    tx_count       = 0;
    errors         = 0;
    tests_failed   = 0;
    $readmemh("bench/fetch_patterns.hex", pat);

    stream_test(1, "in-order memory", 20);
    stream_test(2, "out-of-order memory", 20);
    stream_test(3, "decode back-pressure", 20);

    // Window of 8 sequence numbers without commits
    e0 = errors;
    configure(3);
    reset_dut();
    wait_rx(8, 1000);
    quiet_check(50, 8);
    commit_budget = 3;
    wait_rx(11, 1000);
    quiet_check(50, 11);
    report(4, "sequence window", e0);

    stream_test(5, "sequence wrap", 20);

    // Reset in the middle of a stream
    e0 = errors;
    configure(5);
    reset_dut();
    wait_rx(7, 1000);
    reset_dut();
    wait_rx(6, 1000);
    report(6, "reset mid-stream", e0);

    assert_fails = fetch_unit_inst.fetch_unit_assert_inst.fail_count;
    $display("Tests run 6, failed %0d, errors %0d, assertion failures %0d",
             tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/fetch_pkg.sv
rtl/mem_pkg.sv
rtl/slot_if.sv
rtl/fetch_issue.sv
rtl/fetch_slot.sv
rtl/fetch_deliver.sv
rtl/fetch_unit.sv
bench/fetch_unit_assert.sv
bench/fetch_unit_tb.sv

// File: rtl/fetch_deliver.sv
/*
 * In-order drain of fetch slots into a registered
 * val/rdy decode output stage
 */
`timescale 1ns/100ps

module fetch_deliver #(
  parameter int num_slots    = 4,
  parameter int seq_num_bits = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  slot_if.deliver                 slots [num_slots],
  output logic                    d_val,
  input  logic                    d_rdy,
  output fetch_pkg::word_t        d_inst,
  output fetch_pkg::word_t        d_pc,
  output logic [seq_num_bits-1:0] d_seq_num
);

  localparam int slot_bits = $clog2(num_slots);

  logic [slot_bits-1:0]    head_q;
  logic [slot_bits-1:0]    head_next;
  logic [num_slots-1:0]    full_vec;
  fetch_pkg::word_t        inst_vec [num_slots];
  fetch_pkg::word_t        pc_vec   [num_slots];
  logic [seq_num_bits-1:0] seq_vec  [num_slots];
  // Output stage
  logic                    val_q;
  fetch_pkg::word_t        inst_q;
  fetch_pkg::word_t        pc_q;
  logic [seq_num_bits-1:0] seq_q;
  logic                    xfer;
  logic                    load;

  assign xfer      = val_q && d_rdy;
  assign head_next = xfer ? head_q + 1'b1 : head_q;
  // Stage refills when empty or draining
  assign load      = !val_q || xfer;

  // ---------------------------------------------------------------
  // Slot gather and release
  // ---------------------------------------------------------------

  for (genvar i = 0; i < num_slots; i++) begin : g_slot
    assign full_vec[i]           = slots[i].full;
    assign inst_vec[i]           = slots[i].inst;
    assign pc_vec[i]             = slots[i].pc;
    assign seq_vec[i]            = slots[i].seq;
    // Head slot frees on the decode transfer
    assign slots[i].release_slot = xfer && (head_q == slot_bits'(i));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      val_q  <= 1'b0;
    end else begin
      head_q <= head_next;
      if (load) begin
        val_q <= full_vec[head_next];
      end
    end
  end

  // Message held stable under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      inst_q <= inst_vec[head_next];
      pc_q   <= pc_vec[head_next];
      seq_q  <= seq_vec[head_next];
    end
  end

  assign d_val     = val_q;
  assign d_inst    = inst_q;
  assign d_pc      = pc_q;
  assign d_seq_num = seq_q;

endmodule

// File: rtl/fetch_issue.sv
/*
 * PC generator, round-robin slot allocator, sequence window
 * tracking and memory request driver
 */
`timescale 1ns/100ps

module fetch_issue #(
  parameter int               num_slots    = 4,
  parameter int               seq_num_bits = 3,
  parameter fetch_pkg::word_t reset_pc     = 32'h0000_0100
) (
  input  logic                              clk,
  input  logic                              rst,
  slot_if.issue                             slots [num_slots],
  output logic                              mem_req_val,
  input  logic                              mem_req_rdy,
  output fetch_pkg::word_t                  mem_req_addr,
  output logic [mem_pkg::max_opaq_bits-1:0] mem_req_opaq,
  input  logic                              commit_val,
  input  logic [seq_num_bits-1:0]           commit_seq_num
);

  localparam int          slot_bits = $clog2(num_slots);
  localparam int          opaq_bits = mem_pkg::max_opaq_bits;
  localparam int unsigned window    = fetch_pkg::seq_window(seq_num_bits);
  localparam logic [seq_num_bits:0] win_lim = window[seq_num_bits:0];

  // Request register doubles as PC and slot pointer
  mem_pkg::req_t           req_q;
  logic                    req_val_q;
  // One extra bit so a full window differs from an empty one
  logic [seq_num_bits:0]   seq_q;
  logic [seq_num_bits:0]   seq_next;
  logic [seq_num_bits:0]   oldest_q;
  logic [seq_num_bits:0]   oldest_next;
  logic [slot_bits-1:0]    ptr;
  logic [slot_bits-1:0]    ptr_next;
  logic [num_slots-1:0]    busy_vec;
  logic                    xfer;
  logic                    commit_ok;
  logic                    can_issue;

  assign ptr  = req_q.opaq[slot_bits-1:0];
  assign xfer = req_val_q && mem_req_rdy;

  // Commits arrive in order, so only the oldest one counts
  assign commit_ok = commit_val && (commit_seq_num == oldest_q[seq_num_bits-1:0]);

  // ---------------------------------------------------------------
  // Next request decision
  // ---------------------------------------------------------------

  always_comb begin
    ptr_next    = xfer ? ptr + 1'b1 : ptr;
    seq_next    = xfer ? seq_q + 1'b1 : seq_q;
    oldest_next = commit_ok ? oldest_q + 1'b1 : oldest_q;
    // Target slot must be free and a sequence number must be spare
    can_issue   = !busy_vec[ptr_next] && ((seq_next - oldest_next) < win_lim);
  end

  // Slot allocate fan-out
  for (genvar i = 0; i < num_slots; i++) begin : g_slot
    assign busy_vec[i]        = slots[i].busy;
    assign slots[i].alloc     = xfer && (ptr == slot_bits'(i));
    assign slots[i].alloc_pc  = req_q.addr;
    assign slots[i].alloc_seq = seq_q[seq_num_bits-1:0];
  end

  // ---------------------------------------------------------------
  // State
  // ---------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      req_val_q  <= 1'b0;
      req_q.addr <= reset_pc;
      req_q.opaq <= '0;
      seq_q      <= '0;
      oldest_q   <= '0;
    end else begin
      seq_q    <= seq_next;
      oldest_q <= oldest_next;
      if (xfer) begin
        req_q.addr <= fetch_pkg::next_pc(req_q.addr);
        req_q.opaq <= opaq_bits'(ptr_next);
      end
      // Hold val, addr and tag until accepted
      if (!req_val_q || xfer) begin
        req_val_q <= can_issue;
      end
    end
  end

  assign mem_req_val  = req_val_q;
  assign mem_req_addr = req_q.addr;
  assign mem_req_opaq = req_q.opaq;

endmodule

// File: rtl/fetch_pkg.sv
/*
 * Fetch-side word type, decode message field widths
 * and sequence number helpers
 */
package fetch_pkg;

  // Instruction and address words share one width
  localparam int inst_width = 32;
  localparam int pc_width   = 32;

  typedef logic [inst_width-1:0] word_t;

  // Sequential fetch stride in bytes
  localparam word_t pc_step = 32'd4;

  function automatic word_t next_pc(word_t pc);
    return pc + pc_step;
  endfunction

  // Number of sequence numbers that may be in flight at once
  function automatic int unsigned seq_window(int unsigned seq_num_bits);
    return 1 << seq_num_bits;
  endfunction

  // Flat width of a decode message: inst, pc, seq_num
  function automatic int unsigned d_msg_bits(int unsigned seq_num_bits);
    return inst_width + pc_width + seq_num_bits;
  endfunction

endpackage

// File: rtl/fetch_slot.sv
/*
 * One in-flight fetch entry: free, waiting or full,
 * holding its pc, sequence number and instruction
 */
`timescale 1ns/100ps

module fetch_slot #(
  parameter int idx          = 0,
  parameter int seq_num_bits = 3
) (
  input logic  clk,
  input logic  rst,
  slot_if.slot s
);

  localparam int opaq_bits = mem_pkg::max_opaq_bits;

  typedef enum logic [1:0] {
    st_free,
    st_wait,
    st_full
  } state_t;

  state_t                  state_q;
  fetch_pkg::word_t        pc_q;
  fetch_pkg::word_t        inst_q;
  logic [seq_num_bits-1:0] seq_q;
  logic                    fill_hit;

  // Top decodes the low tag bits; upper bits must be zero too
  assign fill_hit = s.fill && (s.fill_data.opaq == opaq_bits'(idx));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_free;
    end else begin
      case (state_q)
        st_free: if (s.alloc)        state_q <= st_wait;
        st_wait: if (fill_hit)       state_q <= st_full;
        st_full: if (s.release_slot) state_q <= st_free;
        default:                     state_q <= st_free;
      endcase
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (s.alloc) begin
      pc_q  <= s.alloc_pc;
      seq_q <= s.alloc_seq;
    end
    if (fill_hit) begin
      inst_q <= s.fill_data.data;
    end
  end

  assign s.busy = (state_q != st_free);
  assign s.full = (state_q == st_full);
  assign s.pc   = pc_q;
  assign s.seq  = seq_q;
  assign s.inst = inst_q;

endmodule

// File: rtl/fetch_unit.sv
/*
 * Fetch unit top: issue, slot array, in-order delivery
 * and memory response fan-out
 */
`timescale 1ns/100ps

module fetch_unit #(
  parameter int               num_slots    = 4,
  parameter int               seq_num_bits = 3,
  parameter fetch_pkg::word_t reset_pc     = 32'h0000_0100
) (
  input  logic                              clk,
  input  logic                              rst,
  // Memory request
  output logic                              mem_req_val,
  input  logic                              mem_req_rdy,
  output fetch_pkg::word_t                  mem_req_addr,
  output logic [mem_pkg::max_opaq_bits-1:0] mem_req_opaq,
  // Memory response, no back-pressure
  input  logic                              mem_resp_val,
  input  logic [mem_pkg::max_opaq_bits-1:0] mem_resp_opaq,
  input  fetch_pkg::word_t                  mem_resp_data,
  // Decode
  output logic                              d_val,
  input  logic                              d_rdy,
  output fetch_pkg::word_t                  d_inst,
  output fetch_pkg::word_t                  d_pc,
  output logic [seq_num_bits-1:0]           d_seq_num,
  // Commit
  input  logic                              commit_val,
  input  logic [seq_num_bits-1:0]           commit_seq_num
);

  localparam int slot_bits = $clog2(num_slots);

  mem_pkg::resp_t resp;

  slot_if #(.seq_num_bits(seq_num_bits)) slot_ifs [num_slots] ();

  assign resp.data = mem_resp_data;
  assign resp.opaq = mem_resp_opaq;

  fetch_issue #(
    .num_slots    (num_slots),
    .seq_num_bits (seq_num_bits),
    .reset_pc     (reset_pc)
  ) fetch_issue_inst (
    .clk            (clk),
    .rst            (rst),
    .slots          (slot_ifs),
    .mem_req_val    (mem_req_val),
    .mem_req_rdy    (mem_req_rdy),
    .mem_req_addr   (mem_req_addr),
    .mem_req_opaq   (mem_req_opaq),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num)
  );

  // ---------------------------------------------------------------
  // Slots, fill strobe decoded from the response tag
  // ---------------------------------------------------------------

  for (genvar i = 0; i < num_slots; i++) begin : g_slot
    assign slot_ifs[i].fill      = mem_resp_val && (resp.opaq[slot_bits-1:0] == slot_bits'(i));
    assign slot_ifs[i].fill_data = resp;

    fetch_slot #(
      .idx          (i),
      .seq_num_bits (seq_num_bits)
    ) fetch_slot_inst (
      .clk (clk),
      .rst (rst),
      .s   (slot_ifs[i])
    );
  end

  fetch_deliver #(
    .num_slots    (num_slots),
    .seq_num_bits (seq_num_bits)
  ) fetch_deliver_inst (
    .clk       (clk),
    .rst       (rst),
    .slots     (slot_ifs),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_inst    (d_inst),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num)
  );

endmodule

// File: rtl/mem_pkg.sv
/*
 * Instruction memory request and response records
 */
package mem_pkg;

  // Tag field is sized for the largest slot count
  localparam int max_opaq_bits = 4;

  // Word read request
  typedef struct packed {
    fetch_pkg::word_t         addr;
    logic [max_opaq_bits-1:0] opaq;
  } req_t;

  // Read data, returned with the request tag
  typedef struct packed {
    fetch_pkg::word_t         data;
    logic [max_opaq_bits-1:0] opaq;
  } resp_t;

endpackage

// File: rtl/slot_if.sv
/*
 * Per-slot bundle: allocate from issue, fill from memory,
 * slot status and contents, release from deliver
 */
`timescale 1ns/100ps

interface slot_if #(
  parameter int seq_num_bits = 3
) ();

  // Allocate, one-cycle strobe with the request's pc and seq
  logic                    alloc;
  fetch_pkg::word_t        alloc_pc;
  logic [seq_num_bits-1:0] alloc_seq;

  // Fill strobe, already qualified by tag at the top
  logic                    fill;
  mem_pkg::resp_t          fill_data;

  // Slot state and held contents
  logic                    busy;
  logic                    full;
  fetch_pkg::word_t        pc;
  logic [seq_num_bits-1:0] seq;
  fetch_pkg::word_t        inst;

  // Drain strobe from deliver
  logic                    release_slot;

  modport issue (output alloc, alloc_pc, alloc_seq, input busy);

  modport slot (
    input  alloc, alloc_pc, alloc_seq, fill, fill_data, release_slot,
    output busy, full, pc, seq, inst
  );

  modport deliver (input full, pc, seq, inst, output release_slot);

endinterface

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb \
  -f files.f --Mdir obj_dir -o fetch_unit_sim
./obj_dir/fetch_unit_sim | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1
